// ==== src/motorPkg.sv ====
package motorPkg;

    // electrical cycle layout
    localparam int stepCount   = 12;
    localparam int activeSteps = 6;
    localparam int phaseOffset = 4;

    // datapath widths
    localparam int pwmLenW  = 12;
    localparam int posW     = 16;
    localparam int stepLenW = 16;

    // step index inside the twelve-step cycle, 0 to 11
    typedef logic [3:0] stepT;

    typedef struct packed {
        logic                       enable;
        logic [stepLenW-1:0]        stepLen;
        logic [pwmLenW-1:0]         pwmLen;
        logic [pwmLenW-1:0]         pwmMin;
        // index 0 is phase A
        logic [2:0][posW-1:0]       duty;
    } motorCfgT;

    typedef struct packed {
        stepT sgStep;
        logic stepFirst;
        logic stepLast;
    } stepEvtT;

    typedef struct packed {
        logic [posW-1:0] lost;
        logic            lostValid;
    } phaseStatT;

    // generator state: idle between steps, waitPeriod while low, pulse while driving
    typedef enum logic [1:0] {
        idle       = 2'd0,
        waitPeriod = 2'd1,
        pulse      = 2'd2
    } pwmStateE;

endpackage

// ==== src/busPkg.sv ====
package busPkg;

    localparam int apbAddrW = 8;
    localparam int apbDataW = 32;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [apbAddrW-1:0] paddr;
        logic [apbDataW-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [apbDataW-1:0] prdata;
        logic                pready;
        logic                pslverr;
    } apbRspT;

    // register map, byte addresses
    typedef enum logic [apbAddrW-1:0] {
        regCtrl    = 8'h00,
        regStepLen = 8'h04,
        regPwmLen  = 8'h08,
        regPwmMin  = 8'h0C,
        regDutyA   = 8'h10,
        regDutyB   = 8'h14,
        regDutyC   = 8'h18,
        // status registers below, read-only
        regStep    = 8'h1C,
        regLostA   = 8'h20,
        regLostB   = 8'h24,
        regLostC   = 8'h28
    } regAddrE;

endpackage

// ==== src/pwmRegFile.sv ====
`timescale 1ns/1ps

module pwmRegFile
    import motorPkg::*;
    import busPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  apbReqT    apbReq,
    input  stepEvtT   stepEvt,
    input  phaseStatT statA,
    input  phaseStatT statB,
    input  phaseStatT statC,
    output apbRspT    apbRsp,
    output motorCfgT  cfg
);

    regAddrE             addr;
    logic                access;
    logic                wrAccess;
    logic                writable;
    logic                readable;
    logic [apbDataW-1:0] rdData;
    phaseStatT           statAll [3];
    logic [posW-1:0]     lostReg [3];

    assign addr       = regAddrE'(apbReq.paddr);
    assign access     = apbReq.psel && apbReq.penable;
    assign wrAccess   = access && apbReq.pwrite && writable;
    assign statAll[0] = statA;
    assign statAll[1] = statB;
    assign statAll[2] = statC;

    // address decode and read mux
    always_comb begin
        writable = 1'b0;
        readable = 1'b1;
        rdData   = '0;
        case (addr)
            regCtrl: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.enable);
            end
            regStepLen: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.stepLen);
            end
            regPwmLen: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.pwmLen);
            end
            regPwmMin: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.pwmMin);
            end
            regDutyA: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.duty[0]);
            end
            regDutyB: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.duty[1]);
            end
            regDutyC: begin
                writable = 1'b1;
                rdData   = apbDataW'(cfg.duty[2]);
            end
            regStep:  rdData = apbDataW'(stepEvt.sgStep);
            regLostA: rdData = apbDataW'(lostReg[0]);
            regLostB: rdData = apbDataW'(lostReg[1]);
            regLostC: rdData = apbDataW'(lostReg[2]);
            default:  readable = 1'b0;
        endcase
    end

    // zero-wait slave, errors return no data
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access && (apbReq.pwrite ? !writable : !readable);
    assign apbRsp.prdata  = (access && !apbReq.pwrite && readable) ? rdData : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfg <= '0;
        end else if (wrAccess) begin
            case (addr)
                regCtrl:    cfg.enable  <= apbReq.pwdata[0];
                regStepLen: cfg.stepLen <= apbReq.pwdata[stepLenW-1:0];
                regPwmLen:  cfg.pwmLen  <= apbReq.pwdata[pwmLenW-1:0];
                regPwmMin:  cfg.pwmMin  <= apbReq.pwdata[pwmLenW-1:0];
                regDutyA:   cfg.duty[0] <= apbReq.pwdata[posW-1:0];
                regDutyB:   cfg.duty[1] <= apbReq.pwdata[posW-1:0];
                regDutyC:   cfg.duty[2] <= apbReq.pwdata[posW-1:0];
                default:    cfg.enable  <= cfg.enable;
            endcase
        end
    end

    // keep the last lost value each phase reported
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 3; i++) begin
                lostReg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (statAll[i].lostValid) begin
                    lostReg[i] <= statAll[i].lost;
                end
            end
        end
    end

    // an error response only ends a proper setup-then-access transfer
    errOnlyInAccess: assert property (@(posedge clk) disable iff (!arstN)
        apbRsp.pslverr |-> access && $past(apbReq.psel && !apbReq.penable));

endmodule

// ==== src/stepSequencer.sv ====
`timescale 1ns/1ps

module stepSequencer
    import motorPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  motorCfgT cfg,
    output stepEvtT  stepEvt
);

    logic [stepLenW-1:0] stepCnt;
    stepT                sgStep;
    logic                lastCycle;

    // a step length of 0 behaves like 1
    assign lastCycle = ({1'b0, stepCnt} + 1'b1) >= {1'b0, cfg.stepLen};

    assign stepEvt.sgStep    = sgStep;
    assign stepEvt.stepFirst = cfg.enable && (stepCnt == '0);
    assign stepEvt.stepLast  = cfg.enable && lastCycle;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepCnt <= '0;
            sgStep  <= '0;
        end else if (!cfg.enable) begin
            stepCnt <= '0;
            sgStep  <= '0;
        end else if (lastCycle) begin
            stepCnt <= '0;
            // wrap after step 11
            if (sgStep == stepT'(stepCount - 1)) begin
                sgStep <= '0;
            end else begin
                sgStep <= sgStep + 1'b1;
            end
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (!arstN)
        sgStep <= stepT'(stepCount - 1));

endmodule

// ==== src/phasePwmGen.sv ====
`timescale 1ns/1ps

module phasePwmGen
    import motorPkg::*;
#(
    parameter int phaseIdx = 0
) (
    input  logic      clk,
    input  logic      arstN,
    input  motorCfgT  cfg,
    input  stepEvtT   stepEvt,
    output logic      pwm,
    output phaseStatT stat
);

    pwmStateE           state;
    pwmStateE           stateNext;
    logic [4:0]         relRaw;
    logic [3:0]         relStep;
    logic               inWindow;
    logic               active;
    logic [posW-1:0]    duty;
    logic [pwmLenW-1:0] periodCnt;
    logic               periodStart;
    logic [posW-1:0]    remain;
    logic [posW-1:0]    posSum;
    logic               pulseOk;
    logic [posW-1:0]    width;
    logic [posW-1:0]    pulseCnt;
    logic [posW-1:0]    wantAcc;
    logic [posW-1:0]    realAcc;
    logic [posW-1:0]    wantNow;
    logic [posW-1:0]    realNow;

    // commutation window, step shifted back by this phase's offset
    assign relRaw   = 5'(stepEvt.sgStep) + 5'(stepCount - phaseOffset * phaseIdx);
    assign relStep  = (relRaw >= 5'(stepCount)) ? 4'(relRaw - 5'(stepCount)) : relRaw[3:0];
    assign inWindow = relStep < 4'(activeSteps);
    assign active   = cfg.enable && inWindow;

    assign duty = cfg.duty[phaseIdx];

    // new period at step start or once pwmLen cycles have passed
    assign periodStart = active && (stepEvt.stepFirst ||
                         (state != idle && periodCnt >= cfg.pwmLen));

    // remainder is dropped at the start of every step
    assign posSum  = (stepEvt.stepFirst ? '0 : remain) + duty;
    assign pulseOk = posSum >= posW'(cfg.pwmMin);
    assign width   = (posSum > posW'(cfg.pwmLen)) ? posW'(cfg.pwmLen) : posSum;

    // totals including the current cycle, used at step end
    assign wantNow = (stepEvt.stepFirst ? '0 : wantAcc) + (periodStart ? duty : '0);
    assign realNow = (stepEvt.stepFirst ? '0 : realAcc) + posW'(pwm);

    assign pwm = (state == pulse);

    always_comb begin
        stateNext = state;
        if (!active || stepEvt.stepLast) begin
            stateNext = idle;
        end else if (periodStart) begin
            stateNext = (pulseOk && width != '0) ? pulse : waitPeriod;
        end else if (state == pulse && pulseCnt == posW'(1)) begin
            stateNext = waitPeriod;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= idle;
            periodCnt <= '0;
            pulseCnt  <= '0;
        end else begin
            state <= stateNext;
            if (periodStart) begin
                periodCnt <= pwmLenW'(1);
            end else if (state != idle) begin
                periodCnt <= periodCnt + 1'b1;
            end
            if (stateNext == idle) begin
                pulseCnt <= '0;
            end else if (periodStart) begin
                pulseCnt <= pulseOk ? width : '0;
            end else if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - 1'b1;
            end
        end
    end

    // carried on-time and the want/real sums of the running step
    always_ff @(posedge clk) begin
        if (active) begin
            if (periodStart) begin
                remain <= pulseOk ? posSum - width : posSum;
            end
            wantAcc <= wantNow;
            realAcc <= realNow;
        end
    end

    // lost on-time of the finished step, zero outside the window
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stat <= '0;
        end else begin
            stat.lostValid <= stepEvt.stepLast;
            if (stepEvt.stepLast) begin
                stat.lost <= active ? wantNow - realNow : '0;
            end
        end
    end

    pwmInWindow: assert property (@(posedge clk) disable iff (!arstN)
        pwm |-> inWindow);

endmodule

// ==== src/motorPwmTop.sv ====
`timescale 1ns/1ps

module motorPwmTop
    import motorPkg::*;
    import busPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  apbReqT     apbReq,
    output apbRspT     apbRsp,
    output logic [2:0] pwmOut
);

    motorCfgT  cfg;
    stepEvtT   stepEvt;
    phaseStatT statA;
    phaseStatT statB;
    phaseStatT statC;

    pwmRegFile regFile (
        .clk     (clk),
        .arstN   (arstN),
        .apbReq  (apbReq),
        .stepEvt (stepEvt),
        .statA   (statA),
        .statB   (statB),
        .statC   (statC),
        .apbRsp  (apbRsp),
        .cfg     (cfg)
    );

    stepSequencer sequencer (
        .clk     (clk),
        .arstN   (arstN),
        .cfg     (cfg),
        .stepEvt (stepEvt)
    );

    // phases are four steps apart
    phasePwmGen #(.phaseIdx(0)) phaseA (
        .clk     (clk),
        .arstN   (arstN),
        .cfg     (cfg),
        .stepEvt (stepEvt),
        .pwm     (pwmOut[0]),
        .stat    (statA)
    );

    phasePwmGen #(.phaseIdx(1)) phaseB (
        .clk     (clk),
        .arstN   (arstN),
        .cfg     (cfg),
        .stepEvt (stepEvt),
        .pwm     (pwmOut[1]),
        .stat    (statB)
    );

    phasePwmGen #(.phaseIdx(2)) phaseC (
        .clk     (clk),
        .arstN   (arstN),
        .cfg     (cfg),
        .stepEvt (stepEvt),
        .pwm     (pwmOut[2]),
        .stat    (statC)
    );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs   = 40,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release reset on a falling edge, away from the sampling edge
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== test/motorPwmTb.sv ====
`timescale 1ns/1ps

module motorPwmTb
    import motorPkg::*;
    import busPkg::*;
;

    logic       clk;
    logic       arstN;
    apbReqT     apbReq;
    apbRspT     apbRsp;
    logic [2:0] pwmOut;

    // test cases from the stim file
    int              caseCnt;
    logic [15:0]     cStepLen [$];
    logic [15:0]     cPwmLen [$];
    logic [15:0]     cPwmMin [$];
    logic [15:0]     cDuty [$][3];
    int              cSteps [$];
    int              wdCycles;
    bit              wdArmed;

    // reference model of the running case
    bit              enExp;
    int              stepLenM;
    int              pwmLenM;
    int              pwmMinM;
    logic [15:0]     dutyM [3];
    int              stepM;
    int              cntM;
    bit              runM [3];
    int              pcM [3];
    int              leftM [3];
    logic [15:0]     remM [3];
    logic [15:0]     wantM [3];
    logic [15:0]     realM [3];
    logic [15:0]     lostM [3];
    int              stepNextM;
    int              doneCnt;

    clockGen clkGen (
        .clk   (clk),
        .arstN (arstN)
    );

    motorPwmTop UUT (
        .clk    (clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .pwmOut (pwmOut)
    );

    task automatic failNow();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkPwm(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("FAIL pwmOut got %h expected %h at %0t", got, exp, $time);
            failNow();
        end
    endtask

    task automatic checkStep(input stepT got, input stepT exp);
        if (got !== exp) begin
            $display("FAIL sgStep got %h expected %h", got, exp);
            failNow();
        end
    endtask

    task automatic checkLost(input int phase, input logic [posW-1:0] got,
                             input logic [posW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL lost[%0d] got %h expected %h", phase, got, exp);
            failNow();
        end
    endtask

    task automatic checkRsp(input apbRspT got, input apbRspT exp);
        if (got !== exp) begin
            $display("FAIL apbRsp got %h expected %h", got, exp);
            failNow();
        end
    endtask

    // one APB transfer, setup then access, response sampled mid-access
    task automatic apbXfer(input logic wr, input logic [7:0] addr,
                           input logic [31:0] wdata, output apbRspT rsp);
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        rsp = apbRsp;
        @(posedge clk);
        apbReq <= '0;
    endtask

    task automatic writeCheck(input logic [7:0] addr, input logic [31:0] data);
        apbRspT rsp;
        apbXfer(1'b1, addr, data, rsp);
        checkRsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0});
        apbXfer(1'b0, addr, 32'h0, rsp);
        checkRsp(rsp, '{prdata: data, pready: 1'b1, pslverr: 1'b0});
    endtask

    task automatic readOk(input logic [7:0] addr, output logic [31:0] data);
        apbRspT rsp;
        apbXfer(1'b0, addr, 32'h0, rsp);
        checkRsp(rsp, '{prdata: rsp.prdata, pready: 1'b1, pslverr: 1'b0});
        data = rsp.prdata;
    endtask

    task automatic loadStim();
        int    fd;
        int    n;
        string line;
        logic [15:0] sl;
        logic [15:0] pl;
        logic [15:0] pm;
        logic [15:0] d [3];
        int    steps;
        fd = $fopen("test/motorPwmStim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            failNow();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %d", sl, pl, pm, d[0], d[1], d[2], steps);
                if (n == 7) begin
                    // ffff marks a random duty up to one and a half periods
                    for (int k = 0; k < 3; k++) begin
                        if (d[k] == 16'hFFFF) begin
                            d[k] = 16'($urandom % (32'(pl) + 32'(pl) / 2 + 1));
                        end
                    end
                    cStepLen.push_back(sl);
                    cPwmLen.push_back(pl);
                    cPwmMin.push_back(pm);
                    cDuty.push_back(d);
                    cSteps.push_back(steps);
                end
            end
        end
        $fclose(fd);
        caseCnt = cStepLen.size();
    endtask

    // cycle model of sequencer and generators, checked on the falling edge
    always @(negedge clk) begin
        bit          first;
        bit          last;
        bit          act [3];
        bit          ps [3];
        logic [2:0]  expPwm;
        logic [15:0] wantN;
        logic [15:0] realN;
        logic [15:0] sum;
        logic [15:0] w;
        if (arstN && enExp) begin
            first = (cntM == 0);
            last  = (cntM >= stepLenM - 1);
            for (int k = 0; k < 3; k++) begin
                act[k] = ((stepM + 12 - 4 * k) % 12) < 6;
                ps[k]  = act[k] && (first || (runM[k] && pcM[k] >= pwmLenM));
                expPwm[k] = leftM[k] > 0;
            end
            checkPwm(pwmOut, expPwm);
            for (int k = 0; k < 3; k++) begin
                wantN = (first ? 16'd0 : wantM[k]) + (ps[k] ? dutyM[k] : 16'd0);
                realN = (first ? 16'd0 : realM[k]) + 16'(expPwm[k]);
                if (act[k]) begin
                    wantM[k] = wantN;
                    realM[k] = realN;
                end
                if (last) begin
                    lostM[k] = act[k] ? wantN - realN : 16'd0;
                end
                if (ps[k]) begin
                    sum = (first ? 16'd0 : remM[k]) + dutyM[k];
                    if (32'(sum) >= pwmMinM) begin
                        w = (32'(sum) > pwmLenM) ? 16'(pwmLenM) : sum;
                        leftM[k] = 32'(w);
                        remM[k]  = sum - w;
                    end else begin
                        leftM[k] = 0;
                        remM[k]  = sum;
                    end
                    pcM[k]  = 1;
                    runM[k] = 1'b1;
                end else begin
                    if (runM[k]) pcM[k]++;
                    if (leftM[k] > 0) leftM[k]--;
                end
                if (!act[k] || last) begin
                    runM[k]  = 1'b0;
                    leftM[k] = 0;
                end
            end
            if (last) begin
                cntM      = 0;
                stepM     = (stepM + 1) % 12;
                stepNextM = stepM;
                doneCnt++;
            end else begin
                cntM++;
            end
        end else begin
            checkPwm(pwmOut, 3'b000);
            stepM = 0;
            cntM  = 0;
            for (int k = 0; k < 3; k++) begin
                runM[k]  = 1'b0;
                leftM[k] = 0;
                pcM[k]   = 0;
            end
        end
    end

    // watchdog sized from the total length of all cases
    initial begin
        wait (wdArmed);
        repeat (wdCycles) @(posedge clk);
        $display("timeout, the run did not finish in the expected number of cycles");
        failNow();
    end

    initial begin
        apbRspT      rsp;
        logic [31:0] data;
        logic [15:0] lostExp [3];
        int          stepExp;
        apbReq   = '0;
        enExp    = 1'b0;
        doneCnt  = 0;
        wdArmed  = 1'b0;
        void'($urandom(93));
        loadStim();
        wdCycles = 2000;
        for (int c = 0; c < caseCnt; c++) begin
            wdCycles += cSteps[c] * (32'(cStepLen[c]) + 4) + 200;
        end
        wdArmed = 1'b1;
        wait (arstN);

        // error responses
        apbXfer(1'b1, regStep, 32'h5, rsp);
        checkRsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b1});
        apbXfer(1'b0, 8'h40, 32'h0, rsp);
        checkRsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b1});

        for (int c = 0; c < caseCnt; c++) begin
            writeCheck(regStepLen, 32'(cStepLen[c]));
            writeCheck(regPwmLen, 32'(cPwmLen[c]));
            writeCheck(regPwmMin, 32'(cPwmMin[c]));
            writeCheck(regDutyA, 32'(cDuty[c][0]));
            writeCheck(regDutyB, 32'(cDuty[c][1]));
            writeCheck(regDutyC, 32'(cDuty[c][2]));
            stepLenM = 32'(cStepLen[c]);
            pwmLenM  = 32'(cPwmLen[c]);
            pwmMinM  = 32'(cPwmMin[c]);
            dutyM    = cDuty[c];
            doneCnt  = 0;
            apbXfer(1'b1, regCtrl, 32'h1, rsp);
            // step 0 starts in the cycle right after the enabling edge
            enExp = 1'b1;
            checkRsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0});
            apbXfer(1'b0, regCtrl, 32'h0, rsp);
            checkRsp(rsp, '{prdata: 32'h1, pready: 1'b1, pslverr: 1'b0});
            for (int s = 0; s < cSteps[c]; s++) begin
                while (doneCnt < s + 1) @(posedge clk);
                lostExp = lostM;
                stepExp = stepNextM;
                readOk(regLostA, data);
                checkLost(0, data[15:0], lostExp[0]);
                readOk(regLostB, data);
                checkLost(1, data[15:0], lostExp[1]);
                readOk(regLostC, data);
                checkLost(2, data[15:0], lostExp[2]);
                readOk(regStep, data);
                checkStep(stepT'(data[3:0]), stepT'(stepExp));
            end
            apbXfer(1'b1, regCtrl, 32'h0, rsp);
            // the generators keep their registered output for one more cycle
            @(posedge clk);
            enExp = 1'b0;
            checkRsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0});
            readOk(regStep, data);
            checkStep(stepT'(data[3:0]), stepT'(0));
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== test/motorPwmStim.txt ====
# stepLen pwmLen pwmMin dutyA dutyB dutyC (hex), steps to run (decimal)
# a duty of ffff is replaced by a random value
40 10 4 8 8 8 14
30 10 a 3 5 4 12
2a 10 2 c 10 14 12
20 8 3 ffff ffff ffff 12
23 c 6 2 7 b 13

// ==== compile.f ====
src/motorPkg.sv
src/busPkg.sv
src/pwmRegFile.sv
src/stepSequencer.sv
src/phasePwmGen.sv
src/motorPwmTop.sv
test/clockGen.sv
test/motorPwmTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= motorPwmTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
